// ==== Bender.yml ====
package:
  name: sample_merger

sources:
  - include_dirs:
      - design
    files:
      - design/stream_pkg.sv
      - design/sample_stream_if.sv
      - design/stream_input_slice.sv
      - design/frame_counter.sv
      - design/stream_combiner.sv
      - design/sample_merger_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tb_clock_gen.sv
      - testbench/sample_merger_assertions.sv
      - testbench/sample_merger_tb.sv

// ==== all.f ====
+incdir+design
design/stream_pkg.sv
design/sample_stream_if.sv
design/stream_input_slice.sv
design/frame_counter.sv
design/stream_combiner.sv
design/sample_merger_top.sv
testbench/tb_clock_gen.sv
testbench/sample_merger_assertions.sv
testbench/sample_merger_tb.sv

// ==== design/frame_counter.sv ====
// Frame position counter for one source
// Flags the accepted beat that completes each frame

`timescale 1ns/1ps

module frame_counter #(
    parameter int frame_length = 4
) (
    input  logic clock,
    input  logic reset,
    input  logic beat,
    output logic last
);
    import stream_pkg::*;

    localparam beat_count_t last_index = beat_count_t'(frame_length - 1);

    beat_count_t count;

    // Combinational, so the combiner can register it with the beat itself
    assign last = beat && (count == last_index);

    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
        end else if (beat) begin
            if (count == last_index) begin
                count <= '0;
            end else begin
                count <= count + beat_count_t'(1);
            end
        end
    end

endmodule

// ==== design/sample_merger_top.sv ====
// Top level of the three-channel sample merger
// Input slices feeding the priority combiner, plain ports only

`timescale 1ns/1ps

`include "stream_params.svh"

module sample_merger_top (
    input  logic clock,
    input  logic reset,
    input  stream_pkg::sample_t in_1_data,
    input  stream_pkg::dest_t in_1_dest,
    input  stream_pkg::user_t in_1_user,
    input  logic in_1_valid,
    output logic in_1_ready,
    input  stream_pkg::sample_t in_2_data,
    input  stream_pkg::dest_t in_2_dest,
    input  stream_pkg::user_t in_2_user,
    input  logic in_2_valid,
    output logic in_2_ready,
    input  stream_pkg::sample_t in_3_data,
    input  stream_pkg::dest_t in_3_dest,
    input  stream_pkg::user_t in_3_user,
    input  logic in_3_valid,
    output logic in_3_ready,
    output stream_pkg::out_word_t out_data,
    output stream_pkg::dest_t out_dest,
    output stream_pkg::user_t out_user,
    output logic out_last,
    output logic out_valid,
    input  logic out_ready
);
    import stream_pkg::*;

    // Port side of each slice
    sample_stream_if port_link_1 ();
    sample_stream_if port_link_2 ();
    sample_stream_if port_link_3 ();

    // Slice to combiner
    sample_stream_if merge_link_1 ();
    sample_stream_if merge_link_2 ();
    sample_stream_if merge_link_3 ();

    assign port_link_1.data  = in_1_data;
    assign port_link_1.dest  = in_1_dest;
    assign port_link_1.user  = in_1_user;
    assign port_link_1.valid = in_1_valid;
    assign in_1_ready        = port_link_1.ready;

    assign port_link_2.data  = in_2_data;
    assign port_link_2.dest  = in_2_dest;
    assign port_link_2.user  = in_2_user;
    assign port_link_2.valid = in_2_valid;
    assign in_2_ready        = port_link_2.ready;

    assign port_link_3.data  = in_3_data;
    assign port_link_3.dest  = in_3_dest;
    assign port_link_3.user  = in_3_user;
    assign port_link_3.valid = in_3_valid;
    assign in_3_ready        = port_link_3.ready;

    stream_input_slice slice_1 (
        .clock      (clock),
        .reset      (reset),
        .upstream   (port_link_1.sink),
        .downstream (merge_link_1.source)
    );

    stream_input_slice slice_2 (
        .clock      (clock),
        .reset      (reset),
        .upstream   (port_link_2.sink),
        .downstream (merge_link_2.source)
    );

    stream_input_slice slice_3 (
        .clock      (clock),
        .reset      (reset),
        .upstream   (port_link_3.sink),
        .downstream (merge_link_3.source)
    );

    stream_combiner #(
        .dest_in_msb  (1'b1),
        .frame_length (`STREAM_FRAME_LENGTH)
    ) combiner (
        .clock     (clock),
        .reset     (reset),
        .in_1      (merge_link_1.sink),
        .in_2      (merge_link_2.sink),
        .in_3      (merge_link_3.sink),
        .out_data  (out_data),
        .out_dest  (out_dest),
        .out_user  (out_user),
        .out_last  (out_last),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

// ==== design/sample_stream_if.sv ====
// Valid/ready stream of one signed sample with dest and user sideband
// Source and sink modports

`timescale 1ns/1ps

interface sample_stream_if;
    import stream_pkg::*;

    sample_t data;
    dest_t   dest;
    user_t   user;
    logic    valid;
    logic    ready;

    // The source holds a beat stable until valid and ready meet on a clock edge
    modport source (
        output data,
        output dest,
        output user,
        output valid,
        input  ready
    );

    modport sink (
        input  data,
        input  dest,
        input  user,
        input  valid,
        output ready
    );

endinterface

// ==== design/stream_combiner.sv ====
// Fixed-priority merge of three sample streams into one output register
// Output word formatting and per-source frame marking

`timescale 1ns/1ps

module stream_combiner #(
    parameter bit dest_in_msb  = 1'b1,
    parameter int frame_length = 4
) (
    input  logic clock,
    input  logic reset,
    sample_stream_if.sink in_1,
    sample_stream_if.sink in_2,
    sample_stream_if.sink in_3,
    output stream_pkg::out_word_t out_data,
    output stream_pkg::dest_t out_dest,
    output stream_pkg::user_t out_user,
    output logic out_last,
    output logic out_valid,
    input  logic out_ready
);
    import stream_pkg::*;

    logic load_enable;
    logic grant_1;
    logic grant_2;
    logic grant_3;
    logic any_grant;
    logic last_1;
    logic last_2;
    logic last_3;

    sample_t sel_data;
    dest_t   sel_dest;
    user_t   sel_user;

    // Sign-extend the sample and optionally overwrite the top byte with dest
    function automatic out_word_t format_word(input sample_t sample, input dest_t dest);
        out_word_t word;
        word = out_word_t'(sample);
        if (dest_in_msb) begin
            word[$bits(out_word_t)-1 -: $bits(dest_t)] = dest;
        end
        return word;
    endfunction

    // The register may load when empty or when its beat leaves this cycle
    assign load_enable = !out_valid || out_ready;

    // Input 1 always wins, so a busy input 1 can starve the others
    assign grant_1   = load_enable && in_1.valid;
    assign grant_2   = load_enable && !in_1.valid && in_2.valid;
    assign grant_3   = load_enable && !in_1.valid && !in_2.valid && in_3.valid;
    assign any_grant = grant_1 || grant_2 || grant_3;

    assign in_1.ready = grant_1;
    assign in_2.ready = grant_2;
    assign in_3.ready = grant_3;

    always_comb begin
        if (in_1.valid) begin
            sel_data = in_1.data;
            sel_dest = in_1.dest;
            sel_user = in_1.user;
        end else if (in_2.valid) begin
            sel_data = in_2.data;
            sel_dest = in_2.dest;
            sel_user = in_2.user;
        end else begin
            sel_data = in_3.data;
            sel_dest = in_3.dest;
            sel_user = in_3.user;
        end
    end

    // Each source keeps its own frame position
    frame_counter #(.frame_length(frame_length)) counter_1 (
        .clock (clock),
        .reset (reset),
        .beat  (grant_1),
        .last  (last_1)
    );

    frame_counter #(.frame_length(frame_length)) counter_2 (
        .clock (clock),
        .reset (reset),
        .beat  (grant_2),
        .last  (last_2)
    );

    frame_counter #(.frame_length(frame_length)) counter_3 (
        .clock (clock),
        .reset (reset),
        .beat  (grant_3),
        .last  (last_3)
    );

    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else if (load_enable) begin
            out_valid <= any_grant;
            // Only the granted counter can flag, so an OR picks its flag
            out_last  <= last_1 || last_2 || last_3;
        end
    end

    always_ff @(posedge clock) begin
        if (any_grant) begin
            out_data <= format_word(sel_data, sel_dest);
            out_dest <= sel_dest;
            out_user <= sel_user;
        end
    end

endmodule

// ==== design/stream_input_slice.sv ====
// Two-entry skid buffer for one sample stream
// Cuts the ready path between the combiner and the input port

`timescale 1ns/1ps

module stream_input_slice (
    input logic clock,
    input logic reset,
    sample_stream_if.sink upstream,
    sample_stream_if.source downstream
);
    import stream_pkg::*;

    typedef enum logic [1:0] {
        st_empty,
        st_one,
        st_two
    } slice_state_t;

    slice_state_t state;
    slice_state_t state_next;
    logic ready_q;
    logic accept;
    logic consume;

    // Main entry feeds the output, the spill entry catches the beat that
    // arrives while the output is stalled
    sample_t main_data;
    dest_t   main_dest;
    user_t   main_user;
    sample_t spill_data;
    dest_t   spill_dest;
    user_t   spill_user;

    assign accept  = upstream.valid && ready_q;
    assign consume = downstream.valid && downstream.ready;

    always_comb begin
        state_next = state;
        case (state)
            st_empty: begin
                if (accept) state_next = st_one;
            end
            st_one: begin
                if (accept && !consume) state_next = st_two;
                else if (!accept && consume) state_next = st_empty;
            end
            st_two: begin
                if (consume) state_next = st_one;
            end
            default: state_next = st_empty;
        endcase
    end

    // Ready comes from a register, so it never sees the downstream ready
    always_ff @(posedge clock) begin
        if (!reset) begin
            state   <= st_empty;
            ready_q <= 1'b0;
        end else begin
            state   <= state_next;
            ready_q <= (state_next != st_two);
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_two && consume) begin
            main_data <= spill_data;
            main_dest <= spill_dest;
            main_user <= spill_user;
        end else if (accept && (state == st_empty || consume)) begin
            main_data <= upstream.data;
            main_dest <= upstream.dest;
            main_user <= upstream.user;
        end
        if (accept && state == st_one && !consume) begin
            spill_data <= upstream.data;
            spill_dest <= upstream.dest;
            spill_user <= upstream.user;
        end
    end

    assign upstream.ready   = ready_q;
    assign downstream.valid = (state != st_empty);
    assign downstream.data  = main_data;
    assign downstream.dest  = main_dest;
    assign downstream.user  = main_user;

endmodule

// ==== design/stream_params.svh ====
// Width and frame length macros for the sample merger
// Shared by the package and the top level

`ifndef STREAM_PARAMS_SVH
`define STREAM_PARAMS_SVH

// Signed input sample from each channel
`define STREAM_SAMPLE_WIDTH 16

// Formatted output word
`define STREAM_OUT_WIDTH 32

// Sideband fields carried with every beat
`define STREAM_DEST_WIDTH 8
`define STREAM_USER_WIDTH 8

// Beats per frame for each source, small so frames show up in simulation
`define STREAM_FRAME_LENGTH 4

`endif

// ==== design/stream_pkg.sv ====
// Shared vector types for the sample merger
// Sample, sideband, output word and frame counter types

package stream_pkg;

`include "stream_params.svh"

    // One signed sample from a channel
    typedef logic signed [`STREAM_SAMPLE_WIDTH-1:0] sample_t;

    // Sideband fields
    typedef logic [`STREAM_DEST_WIDTH-1:0] dest_t;
    typedef logic [`STREAM_USER_WIDTH-1:0] user_t;

    // Word leaving the combiner
    typedef logic [`STREAM_OUT_WIDTH-1:0] out_word_t;

    // Position of a beat inside its frame
    typedef logic [15:0] beat_count_t;

endpackage

// ==== testbench/sample_merger_assertions.sv ====
// Concurrent assertions on the sample merger top-level handshakes
// Bound into sample_merger_top

`timescale 1ns/1ps

module sample_merger_assertions (
    input logic clock,
    input logic reset,
    input logic in_1_ready,
    input logic in_2_ready,
    input logic in_3_ready,
    input stream_pkg::out_word_t out_data,
    input stream_pkg::dest_t out_dest,
    input stream_pkg::user_t out_user,
    input logic out_last,
    input logic out_valid,
    input logic out_ready
);

    // Number of failed assertions, watched by the testbench
    int failure_count = 0;

    // A stalled output beat must not change until it is taken
    property output_holds_while_stalled;
        @(posedge clock) disable iff (!reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data) && $stable(out_dest)
            && $stable(out_user) && $stable(out_last));
    endproperty

    // Registers were cleared by the edge that sampled reset low
    property idle_during_reset;
        @(posedge clock)
        !reset |=> (!out_valid && !in_1_ready && !in_2_ready && !in_3_ready);
    endproperty

    property last_only_with_valid;
        @(posedge clock) disable iff (!reset)
        out_last |-> out_valid;
    endproperty

    hold_check: assert property (output_holds_while_stalled)
        else begin
            $error("output beat changed while out_ready was low");
            failure_count++;
        end

    reset_check: assert property (idle_during_reset)
        else begin
            $error("out_valid or an input ready was high during reset");
            failure_count++;
        end

    last_check: assert property (last_only_with_valid)
        else begin
            $error("out_last was high without out_valid");
            failure_count++;
        end

endmodule

bind sample_merger_top sample_merger_assertions handshake_checks (
    .clock      (clock),
    .reset      (reset),
    .in_1_ready (in_1_ready),
    .in_2_ready (in_2_ready),
    .in_3_ready (in_3_ready),
    .out_data   (out_data),
    .out_dest   (out_dest),
    .out_user   (out_user),
    .out_last   (out_last),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
);

// ==== testbench/sample_merger_tb.sv ====
// Testbench for the three-channel sample merger
// Drivers, reference model, output compare process and timeout

`timescale 1ns/1ps

`include "stream_params.svh"

module sample_merger_tb;
    import stream_pkg::*;

    // About ten times the cycles that all phases need, stalls included
    localparam int timeout_cycles = 4000;
    localparam int frame_length = `STREAM_FRAME_LENGTH;
    localparam int ext_width = `STREAM_OUT_WIDTH - `STREAM_SAMPLE_WIDTH - `STREAM_DEST_WIDTH;

    typedef struct packed {
        out_word_t word;
        user_t     user;
        logic      last;
    } expected_beat_t;

    logic clock;
    logic reset;
    sample_t in_data [3];
    dest_t in_dest [3];
    user_t in_user [3];
    logic in_valid [3];
    logic in_ready [3];
    out_word_t out_data;
    dest_t out_dest;
    user_t out_user;
    logic out_last;
    logic out_valid;
    logic out_ready;

    // Beats taken by each slice, waiting to show up at the output
    sample_t sent_samples [3][$];
    int sent_count [3];
    int received_count [3];
    int sent_total = 0;
    int received_total = 0;
    int cycle_count = 0;
    int order_log [$];
    bit log_order = 1'b0;
    bit stress_done = 1'b0;
    string test_name = "reset";

    // Extremes first, then a mix of both signs
    sample_t format_samples [12] = '{16'sh8000, 16'sh7fff, 16'shffff, 16'sh0000,
        16'sh0001, 16'shfffe, 16'sh1234, 16'shfedc, 16'sh00ff, 16'shff00,
        16'sh4000, 16'shc000};

    tb_clock_gen clock_source (
        .clock (clock),
        .reset (reset)
    );

    sample_merger_top UUT (
        .clock      (clock),
        .reset      (reset),
        .in_1_data  (in_data[0]),
        .in_1_dest  (in_dest[0]),
        .in_1_user  (in_user[0]),
        .in_1_valid (in_valid[0]),
        .in_1_ready (in_ready[0]),
        .in_2_data  (in_data[1]),
        .in_2_dest  (in_dest[1]),
        .in_2_user  (in_user[1]),
        .in_2_valid (in_valid[1]),
        .in_2_ready (in_ready[1]),
        .in_3_data  (in_data[2]),
        .in_3_dest  (in_dest[2]),
        .in_3_user  (in_user[2]),
        .in_3_valid (in_valid[2]),
        .in_3_ready (in_ready[2]),
        .out_data   (out_data),
        .out_dest   (out_dest),
        .out_user   (out_user),
        .out_last   (out_last),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    // Expected output for the index-th accepted beat of one source
    function automatic expected_beat_t reference_beat(input sample_t sample, input dest_t dest,
                                                      input user_t user, input int index);
        expected_beat_t beat;
        beat.word = {dest, {ext_width{sample[`STREAM_SAMPLE_WIDTH-1]}}, sample};
        beat.user = user;
        beat.last = ((index % frame_length) == frame_length - 1);
        return beat;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("CHECK FAILED %s: expected 0x%0h, actual 0x%0h",
                name, expected, actual));
        end
    endtask

    // Offers one beat and returns on the edge where the slice takes it
    task automatic send_beat(input int src, input sample_t sample, input int gap);
        if (gap > 0) begin
            in_valid[src] <= 1'b0;
            repeat (gap) @(posedge clock);
        end
        in_data[src]  <= sample;
        in_dest[src]  <= dest_t'(src + 1);
        in_user[src]  <= user_t'(sent_count[src]);
        in_valid[src] <= 1'b1;
        do begin
            @(posedge clock);
        end while (!in_ready[src]);
        sent_samples[src].push_back(sample);
        sent_count[src]++;
        sent_total++;
    endtask

    task automatic random_traffic(input int src, input int beats, input int max_gap);
        for (int i = 0; i < beats; i++) begin
            send_beat(src, sample_t'($urandom), $urandom_range(max_gap, 0));
        end
        in_valid[src] <= 1'b0;
    endtask

    // Keeps offering beats until the slice reports it is full
    task automatic fill_source(input int src);
        while (in_ready[src]) begin
            send_beat(src, sample_t'($urandom), 0);
            in_valid[src] <= 1'b0;
            @(posedge clock);
        end
    endtask

    task automatic wait_for_outputs();
        while (received_total < sent_total) @(posedge clock);
    endtask

    initial begin : compare_outputs
        int src;
        sample_t sample;
        expected_beat_t expected;
        forever begin
            @(posedge clock);
            if (reset && out_valid && out_ready) begin
                src = int'(out_dest) - 1;
                if (src < 0 || src > 2) begin
                    fail_run($sformatf("output beat has dest 0x%0h, which is no input", out_dest));
                end else if (sent_samples[src].size() == 0) begin
                    fail_run($sformatf("input %0d produced a beat that was never sent", src + 1));
                end else begin
                    sample = sent_samples[src].pop_front();
                    expected = reference_beat(sample, dest_t'(src + 1),
                        user_t'(received_count[src]), received_count[src]);
                    check_value({test_name, " out_data"}, expected.word, out_data);
                    check_value({test_name, " out_user"}, expected.user, out_user);
                    check_value({test_name, " out_last"}, expected.last, out_last);
                    if (log_order) order_log.push_back(src);
                    received_count[src]++;
                    received_total++;
                end
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < timeout_cycles) begin
            @(posedge clock);
            cycle_count++;
        end
        fail_run("the run timed out before all beats arrived at the output");
    end

    // Watches the failure count of the bound handshake checker
    initial begin : assertion_monitor
        forever begin
            @(posedge clock);
            if (UUT.handshake_checks.failure_count != 0) begin
                fail_run("a handshake assertion on the DUT ports failed");
            end
        end
    end

    initial begin : main_sequence
        int phase_start [3];
        int expected_source [$];
        void'($urandom(98));
        out_ready = 1'b0;
        for (int s = 0; s < 3; s++) begin
            in_data[s] = '0;
            in_dest[s] = '0;
            in_user[s] = '0;
            in_valid[s] = 1'b0;
            sent_count[s] = 0;
            received_count[s] = 0;
        end

        // The first edge clears the registers, so checks start at the second
        @(posedge clock);
        while (!reset) begin
            @(posedge clock);
            check_value("reset out_valid", 0, out_valid);
            for (int s = 0; s < 3; s++) check_value("reset in_ready", 0, in_ready[s]);
        end
        @(posedge clock);
        for (int s = 0; s < 3; s++) check_value("reset released in_ready", 1, in_ready[s]);

        test_name = "formatting";
        out_ready <= 1'b1;
        for (int i = 0; i < 12; i++) send_beat(0, format_samples[i], 0);
        in_valid[0] <= 1'b0;
        wait_for_outputs();

        test_name = "frames";
        fork
            random_traffic(0, 24, 2);
            random_traffic(1, 24, 2);
            random_traffic(2, 24, 2);
        join
        wait_for_outputs();

        // Both entries of every slice plus the output register end up full
        test_name = "priority";
        for (int s = 0; s < 3; s++) phase_start[s] = sent_count[s];
        out_ready <= 1'b0;
        fork
            fill_source(0);
            fill_source(1);
            fill_source(2);
        join
        for (int s = 0; s < 3; s++) check_value("priority full in_ready", 0, in_ready[s]);
        log_order = 1'b1;
        out_ready <= 1'b1;
        wait_for_outputs();
        log_order = 1'b0;
        check_value("priority beat count", 7, order_log.size());
        // Input 1 took the register first, so every input 1 beat leads
        for (int s = 0; s < 3; s++) begin
            repeat (sent_count[s] - phase_start[s]) expected_source.push_back(s);
        end
        for (int i = 0; i < order_log.size(); i++) begin
            check_value("priority source order", expected_source[i], order_log[i]);
        end

        test_name = "backpressure";
        fork
            begin
                fork
                    random_traffic(0, 30, 1);
                    random_traffic(1, 30, 1);
                    random_traffic(2, 30, 1);
                join
                stress_done = 1'b1;
            end
            while (!stress_done) begin
                out_ready <= ($urandom_range(1, 0) == 1);
                @(posedge clock);
            end
        join
        out_ready <= 1'b1;
        wait_for_outputs();

        repeat (4) @(posedge clock);
        if (received_total == sent_total && !out_valid
                && in_ready[0] && in_ready[1] && in_ready[2]) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            fail_run("the DUT was not idle after the last beat or the beat count is wrong");
        end
    end

endmodule

// ==== testbench/tb_clock_gen.sv ====
// Clock and reset source for the testbench
// 100 ns clock period, reset held low for the first 16 rising edges

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);
    localparam int reset_cycles = 16;

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin
        reset = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        reset <= 1'b1;
    end

endmodule
